// File: mipsAlu.sv
// MIPS integer ALU
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsAlu (
    input  logic [`DATA_W-1:0] srcA,
    input  logic [`DATA_W-1:0] srcB,
    input  mipsPkg::aluOpT     op,
    input  logic [4:0]         shamt,
    output logic [`DATA_W-1:0] result,
    output logic               zero
);

    always_comb begin
        case (op)
            mipsPkg::aluAdd:  result = srcA + srcB;
            mipsPkg::aluSubu: result = srcA - srcB;
            mipsPkg::aluOr:   result = srcA | srcB;
            mipsPkg::aluLui:  result = srcB << 16;   // low half of the immediate
            mipsPkg::aluSrl:  result = srcB >> shamt; // rt is shifted, not rs
            mipsPkg::aluSltu: begin
                result    = '0;
                result[0] = (srcA < srcB);
            end
            default:          result = srcA + srcB;
        endcase
    end

    assign zero = (result == '0); // branch compare

endmodule

// File: mipsCp0.sv
// MIPS coprocessor 0
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCp0 (
    input  logic               clk,
    input  logic               arstN,
    input  mipsPkg::cp0ReqT    req,
    input  logic [`DATA_W-1:0] pcIn,
    input  logic [4:0]         regNum,
    input  logic [`DATA_W-1:0] wData,
    output logic [`DATA_W-1:0] rData,
    output logic               excTaken,
    output logic               eretTaken,
    output logic [`DATA_W-1:0] handlerAddr,
    output logic [`DATA_W-1:0] epc
);

    logic [`DATA_W-1:0] count;
    logic [`DATA_W-1:0] compare;
    logic [`DATA_W-1:0] epcReg;
    logic               statusIe;  // Status bit 0
    logic               statusExl; // Status bit 1
    logic               causeTi;   // Cause bit 30
    logic [4:0]         causeCode; // Cause bits 6:2
    logic               irq;

    assign irq       = statusIe && !statusExl && causeTi;
    assign excTaken  = !statusExl && (req.riFound || irq); // RI wins on code below
    assign eretTaken = req.eretReq;

    assign handlerAddr = `EXC_HANDLER;
    assign epc         = epcReg;

    always_comb begin
        rData = '0;
        case (regNum)
            `CP0_COUNT:   rData = count;
            `CP0_COMPARE: rData = compare;
            `CP0_STATUS:  rData = {30'd0, statusExl, statusIe};
            `CP0_CAUSE:   rData = {1'b0, causeTi, 23'd0, causeCode, 2'b00};
            `CP0_EPC:     rData = epcReg;
            default:      rData = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count     <= '0;
            compare   <= '0;
            epcReg    <= '0;
            statusIe  <= 1'b0;
            statusExl <= 1'b0;
            causeTi   <= 1'b0;
            causeCode <= '0;
        end else begin
            count <= count + 32'd1;
            if (count == compare) begin
                causeTi <= 1'b1; // timer match
            end

            // mtc0, Cause is read-only here
            if (req.cp0Write) begin
                case (regNum)
                    `CP0_COUNT: count <= wData;
                    `CP0_COMPARE: begin
                        compare <= wData;
                        causeTi <= 1'b0; // acknowledge timer
                    end
                    `CP0_STATUS: begin
                        statusIe  <= wData[0];
                        statusExl <= wData[1];
                    end
                    `CP0_EPC: epcReg <= wData;
                    default: ;
                endcase
            end

            // entry and return override the mtc0 above
            if (excTaken) begin
                statusExl <= 1'b1;
                epcReg    <= pcIn;
                causeCode <= req.riFound ? `EXC_RI : `EXC_INT;
            end else if (eretTaken) begin
                statusExl <= 1'b0;
            end
        end
    end

    // decoder and EXL gating together keep the two PC overrides apart
    excEretExclusive: assert property (
        @(posedge clk) disable iff (!arstN) !(excTaken && eretTaken)
    );

    // entry raises EXL, which blocks a nested entry
    noExcInHandler: assert property (
        @(posedge clk) disable iff (!arstN) excTaken |=> statusExl
    );

endmodule

// File: mipsCpu.f
+incdir+.
mipsPkg.sv
mipsDecoder.sv
mipsAlu.sv
mipsRegFile.sv
mipsCp0.sv
mipsCpu.sv
mipsCpuTb.sv

// File: mipsCpu.sv
// single-cycle MIPS CPU
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCpu (
    input  logic               clk,
    input  logic               arstN,
    input  logic [4:0]         regAddr,
    output logic [`DATA_W-1:0] regData,
    output logic [`DATA_W-1:0] imAddr,
    input  logic [`DATA_W-1:0] imData,
    output logic [`DATA_W-1:0] dmAddr,
    output logic [`DATA_W-1:0] dmWData,
    output logic               dmWe,
    input  logic [`DATA_W-1:0] dmRData
);

    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] pcNext;
    logic [`DATA_W-1:0] pcPlusOne;
    logic [`DATA_W-1:0] pcBranch;
    logic [`DATA_W-1:0] pcFlow;
    logic [`DATA_W-1:0] signImm;
    logic [`DATA_W-1:0] srcB;
    logic [`DATA_W-1:0] aluResult;
    logic [`DATA_W-1:0] rDataA;
    logic [`DATA_W-1:0] rDataB;
    logic [`DATA_W-1:0] dbgData;
    logic [`DATA_W-1:0] wbData;
    logic [`DATA_W-1:0] cp0RData;
    logic [`DATA_W-1:0] cp0Pc;
    logic [`DATA_W-1:0] handlerAddr;
    logic [`DATA_W-1:0] epc;
    logic [4:0]         rs;
    logic [4:0]         rt;
    logic [4:0]         rd;
    logic [4:0]         wAddr;
    logic               aluZero;
    logic               branchTaken;
    logic               excTaken;
    logic               eretTaken;
    logic               riExc;
    logic               rfWe;
    mipsPkg::ctrlWordT  ctrl;
    mipsPkg::cp0ReqT    cp0Req;
    mipsPkg::pcSelT     pcSel;

    // instruction fields
    assign imAddr  = pc;
    assign rs      = imData[25:21];
    assign rt      = imData[20:16];
    assign rd      = imData[15:11];
    assign signImm = {{16{imData[15]}}, imData[15:0]};

    mipsDecoder decoder (
        .opcode (mipsPkg::opcodeT'(imData[31:26])),
        .funct  (mipsPkg::functT'(imData[5:0])),
        .rs     (rs),
        .ctrl   (ctrl)
    );

    mipsRegFile regFile (
        .clk     (clk),
        .dbgAddr (regAddr),
        .rAddrA  (rs),
        .rAddrB  (rt),
        .wAddr   (wAddr),
        .dbgData (dbgData),
        .rDataA  (rDataA),
        .rDataB  (rDataB),
        .wData   (wbData),
        .wEn     (rfWe)
    );

    assign srcB = ctrl.aluSrc ? signImm : rDataB;

    mipsAlu alu (
        .srcA   (rDataA),
        .srcB   (srcB),
        .op     (ctrl.aluOp),
        .shamt  (imData[10:6]),
        .result (aluResult),
        .zero   (aluZero)
    );

    // program flow without exceptions
    assign pcPlusOne   = pc + 32'd1;
    assign pcBranch    = pcPlusOne + signImm;
    assign branchTaken = ctrl.branch && (aluZero == ctrl.condZero);
    assign pcFlow      = branchTaken ? pcBranch : pcPlusOne;

    // an RI faults on itself, an interrupt returns past the current instruction
    assign cp0Pc = ctrl.riFound ? pc : pcFlow;

    assign cp0Req.riFound  = ctrl.riFound;
    assign cp0Req.eretReq  = ctrl.eretReq;
    assign cp0Req.cp0Write = ctrl.cp0Write;

    mipsCp0 cp0 (
        .clk         (clk),
        .arstN       (arstN),
        .req         (cp0Req),
        .pcIn        (cp0Pc),
        .regNum      (rd),
        .wData       (rDataB),
        .rData       (cp0RData),
        .excTaken    (excTaken),
        .eretTaken   (eretTaken),
        .handlerAddr (handlerAddr),
        .epc         (epc)
    );

    // write-back
    assign riExc  = excTaken && ctrl.riFound;
    assign rfWe   = ctrl.regWrite && !riExc;
    assign wAddr  = ctrl.regDst ? rd : rt;
    assign wbData = ctrl.memToReg ? dmRData :
                    ctrl.cp0ToReg ? cp0RData : aluResult;

    // data memory
    assign dmAddr  = aluResult;
    assign dmWData = rDataB;
    assign dmWe    = ctrl.memWrite && !riExc && arstN; // quiet while held in reset

    always_comb begin
        if (excTaken) begin
            pcSel = mipsPkg::pcExc;
        end else if (eretTaken) begin
            pcSel = mipsPkg::pcEret;
        end else begin
            pcSel = mipsPkg::pcFlow;
        end
    end

    always_comb begin
        case (pcSel)
            mipsPkg::pcExc:  pcNext = handlerAddr;
            mipsPkg::pcEret: pcNext = epc;
            default:         pcNext = pcFlow;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_VEC;
        end else begin
            pc <= pcNext;
        end
    end

    // debug port, r0 slot shows the PC
    assign regData = (regAddr != 5'd0) ? dbgData : pc;

endmodule

// File: mipsCpuTb.sv
// MIPS CPU testbench
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCpuTb;

    localparam int NROWS = 5;

    logic               clk;
    logic               arstN;
    logic [4:0]         regAddr;
    logic [`DATA_W-1:0] regData, imAddr, imData, dmAddr, dmWData, dmRData;
    logic               dmWe;

    logic [`DATA_W-1:0] imem [128];
    logic [`DATA_W-1:0] dmem [64];
    int                 wrCount;
    logic [`DATA_W-1:0] wrAddr, wrData;

    // program table
    logic [`DATA_W-1:0] prog [NROWS][12];
    int                 cycles [NROWS];
    logic [`DATA_W-1:0] pcExp [NROWS];
    bit                 hasPc [NROWS];
    int                 nChk [NROWS];
    logic [4:0]         chkReg [NROWS][8];
    logic [`DATA_W-1:0] chkVal [NROWS][8];
    bit                 hasWr [NROWS];
    logic [`DATA_W-1:0] expWrAddr [NROWS], expWrData [NROWS];
    logic [31:0]        rng;

    mipsCpu uut (.clk(clk), .arstN(arstN), .regAddr(regAddr), .regData(regData),
        .imAddr(imAddr), .imData(imData), .dmAddr(dmAddr), .dmWData(dmWData),
        .dmWe(dmWe), .dmRData(dmRData));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign imData  = imem[imAddr[6:0]];
    assign dmRData = dmem[dmAddr[5:0]];

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 64; i++) dmem[i] <= 32'hd00d_0000 ^ (i * 32'h0101_0101);
            wrCount <= 0;
        end else if (dmWe) begin
            dmem[dmAddr[5:0]] <= dmWData;
            wrCount <= wrCount + 1;
            wrAddr  <= dmAddr;
            wrData  <= dmWData;
            $display("dm write [%0d] = %h at %0t", dmAddr, dmWData, $time);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] sh,
                                         input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encCop0(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd);
        return {6'h10, rs, rt, rd, 11'd0};
    endfunction

    // lui hi then addiu lo, as the ALU rules combine them
    function automatic logic [31:0] luiAddiu(input logic [31:0] v);
        return {v[31:16], 16'h0000} + {{16{v[15]}}, v[15:0]};
    endfunction

    task automatic failValue(input string name, input logic [`DATA_W-1:0] exp,
                             input logic [`DATA_W-1:0] act);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [`DATA_W-1:0] exp,
                             input logic [`DATA_W-1:0] act);
        if (act !== exp) failValue(name, exp, act);
    endtask

    task automatic checkPc(input logic [`DATA_W-1:0] exp, input logic [`DATA_W-1:0] act);
        if (act !== exp) failValue("pc (regData[0])", exp, act);
    endtask

    task automatic checkWrite(input logic [`DATA_W-1:0] eAddr, input logic [`DATA_W-1:0] eData,
                              input logic [`DATA_W-1:0] aAddr, input logic [`DATA_W-1:0] aData);
        if (aAddr !== eAddr) failValue("dmAddr", eAddr, aAddr);
        if (aData !== eData) failValue("dmWData", eData, aData);
    endtask

    task automatic readReg(input logic [4:0] a, output logic [`DATA_W-1:0] v);
        regAddr = a;
        #1;
        v = regData;
    endtask

    task automatic waitWrite(input int limit);
        int n;
        n = 0;
        while (wrCount == 0) begin
            if (n == limit) begin
                $display("timeout: no data-memory write seen within %0d cycles", limit);
                $display("tests failed");
                $fatal(1);
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic addCheck(input int r, input logic [4:0] rg, input logic [`DATA_W-1:0] v);
        chkReg[r][nChk[r]] = rg;
        chkVal[r][nChk[r]] = v;
        nChk[r]++;
    endtask

    task automatic buildTable();
        logic [31:0] a, b, va, vb, c;
        logic [31:0] selfBr;
        selfBr = encI(mipsPkg::opBeq, 5'd0, 5'd0, 16'hffff); // jumps onto itself
        for (int r = 0; r < NROWS; r++) begin
            for (int i = 0; i < 12; i++) prog[r][i] = 32'h0; // nop
            nChk[r]  = 0;
            hasWr[r] = 1'b0;
            hasPc[r] = 1'b1;
        end
        rng = xorshift(rng);
        a   = rng;
        rng = xorshift(rng);
        b   = rng;
        va  = luiAddiu(a);
        vb  = luiAddiu(b);
        // row 0, ALU operations on random operands
        prog[0][0] = encI(mipsPkg::opLui, 5'd0, 5'd1, a[31:16]);
        prog[0][1] = encI(mipsPkg::opAddiu, 5'd1, 5'd1, a[15:0]);
        prog[0][2] = encI(mipsPkg::opLui, 5'd0, 5'd2, b[31:16]);
        prog[0][3] = encI(mipsPkg::opAddiu, 5'd2, 5'd2, b[15:0]);
        prog[0][4] = encR(5'd1, 5'd2, 5'd3, 5'd0, mipsPkg::fnAddu);
        prog[0][5] = encR(5'd1, 5'd2, 5'd4, 5'd0, mipsPkg::fnSubu);
        prog[0][6] = encR(5'd1, 5'd2, 5'd5, 5'd0, mipsPkg::fnOr);
        prog[0][7] = encR(5'd0, 5'd2, 5'd6, 5'd7, mipsPkg::fnSrl);
        prog[0][8] = encR(5'd1, 5'd2, 5'd7, 5'd0, mipsPkg::fnSltu);
        prog[0][9] = selfBr;
        cycles[0] = 12;
        pcExp[0]  = 32'd9;
        addCheck(0, 5'd1, va);
        addCheck(0, 5'd2, vb);
        addCheck(0, 5'd3, va + vb);
        addCheck(0, 5'd4, va - vb);
        addCheck(0, 5'd5, va | vb);
        addCheck(0, 5'd6, vb >> 7);
        addCheck(0, 5'd7, {31'd0, va < vb});
        // row 1, store then load
        rng = xorshift(rng);
        c   = {{16{rng[15]}}, rng[15:0]};
        prog[1][0] = encI(mipsPkg::opAddiu, 5'd0, 5'd1, rng[15:0]);
        prog[1][1] = encI(mipsPkg::opAddiu, 5'd0, 5'd2, 16'd5);
        prog[1][2] = encI(mipsPkg::opSw, 5'd2, 5'd1, 16'd3);
        prog[1][3] = encI(mipsPkg::opLw, 5'd2, 5'd3, 16'd3);
        prog[1][4] = selfBr;
        cycles[1]    = 6;
        pcExp[1]     = 32'd4;
        hasWr[1]     = 1'b1;
        expWrAddr[1] = 32'd8;
        expWrData[1] = c;
        addCheck(1, 5'd3, c);
        // row 2, branches taken and not taken, 8 instructions reach the end
        prog[2][0]  = encI(mipsPkg::opAddiu, 5'd0, 5'd1, 16'd1);
        prog[2][1]  = encR(5'd0, 5'd0, 5'd11, 5'd0, mipsPkg::fnOr);
        prog[2][2]  = encI(mipsPkg::opBeq, 5'd1, 5'd0, 16'd1);  // not taken
        prog[2][3]  = encI(mipsPkg::opAddiu, 5'd0, 5'd10, 16'd2);
        prog[2][4]  = encI(mipsPkg::opBne, 5'd1, 5'd0, 16'd1);  // taken
        prog[2][5]  = encI(mipsPkg::opAddiu, 5'd0, 5'd11, 16'd3);
        prog[2][6]  = encI(mipsPkg::opBne, 5'd0, 5'd0, 16'd1);  // not taken
        prog[2][7]  = encI(mipsPkg::opAddiu, 5'd0, 5'd12, 16'd5);
        prog[2][8]  = encI(mipsPkg::opBeq, 5'd0, 5'd0, 16'd1);  // taken
        prog[2][9]  = encI(mipsPkg::opAddiu, 5'd0, 5'd11, 16'd4);
        prog[2][10] = selfBr;
        cycles[2] = 8;
        pcExp[2]  = 32'd10;
        addCheck(2, 5'd10, 32'd2);
        addCheck(2, 5'd11, 32'd0);
        addCheck(2, 5'd12, 32'd5);
        // row 3, reserved add at pc 2, handler skips it (r25 = 1)
        prog[3][0] = encI(mipsPkg::opAddiu, 5'd0, 5'd25, 16'd1);
        prog[3][1] = encI(mipsPkg::opAddiu, 5'd0, 5'd20, 16'h0077);
        prog[3][2] = encR(5'd0, 5'd0, 5'd20, 5'd0, 6'h20);
        prog[3][3] = encI(mipsPkg::opAddiu, 5'd0, 5'd21, 16'h0021);
        prog[3][4] = selfBr;
        cycles[3] = 14;
        pcExp[3]  = 32'd4;
        addCheck(3, 5'd20, 32'h77);
        addCheck(3, 5'd21, 32'h21);
        addCheck(3, 5'd22, 32'd2);
        // TI is pending from Count matching Compare right after reset
        addCheck(3, 5'd23, 32'h4000_0000 | (32'(`EXC_RI) << 2));
        addCheck(3, 5'd26, 32'd3);
        // row 4, timer interrupt on a counting loop
        prog[4][0] = encI(mipsPkg::opAddiu, 5'd0, 5'd25, 16'd0);
        prog[4][1] = encI(mipsPkg::opAddiu, 5'd0, 5'd24, 16'd0);
        prog[4][2] = encI(mipsPkg::opAddiu, 5'd0, 5'd9, 16'd0);
        prog[4][3] = encI(mipsPkg::opAddiu, 5'd0, 5'd1, 16'd20);
        prog[4][4] = encCop0(5'd4, 5'd1, `CP0_COMPARE);
        prog[4][5] = encI(mipsPkg::opAddiu, 5'd0, 5'd2, 16'd1);
        prog[4][6] = encCop0(5'd4, 5'd2, `CP0_STATUS);  // IE on
        prog[4][7] = encI(mipsPkg::opAddiu, 5'd9, 5'd9, 16'd1);
        prog[4][8] = encI(mipsPkg::opBeq, 5'd0, 5'd0, 16'hfffe);
        cycles[4] = 40;
        hasPc[4]  = 1'b0;
        addCheck(4, 5'd24, 32'd1);
        addCheck(4, 5'd23, 32'h4000_0000 | (32'(`EXC_INT) << 2));
        addCheck(4, 5'd27, 32'd0);
        // match at cycle 21, entry at 22 after the 8th pass, 5 passes after eret
        addCheck(4, 5'd9, 32'd13);
    endtask

    task automatic loadMemory(input int r);
        for (int i = 0; i < 128; i++) imem[i] = 32'h0;
        for (int i = 0; i < 12; i++) imem[i] = prog[r][i];
        // shared handler, EPC advances by r25
        imem[64] = encCop0(5'd0, 5'd22, `CP0_EPC);
        imem[65] = encCop0(5'd0, 5'd23, `CP0_CAUSE);
        imem[66] = encI(mipsPkg::opAddiu, 5'd24, 5'd24, 16'd1);
        imem[67] = encR(5'd22, 5'd25, 5'd26, 5'd0, mipsPkg::fnAddu);
        imem[68] = encCop0(5'd4, 5'd26, `CP0_EPC);
        imem[69] = encCop0(5'd4, 5'd0, `CP0_COMPARE); // clears TI
        imem[70] = encCop0(5'd0, 5'd27, `CP0_CAUSE);
        imem[71] = 32'h4200_0018; // eret
    endtask

    initial begin
        logic [`DATA_W-1:0] v;
        arstN   = 1'b0;
        regAddr = 5'd0;
        rng     = 32'h34be862b;
        buildTable();
        for (int r = 0; r < NROWS; r++) begin
            @(negedge clk);
            arstN = 1'b0;
            loadMemory(r);
            repeat (8) @(negedge clk);
            arstN = 1'b1;
            repeat (cycles[r]) @(negedge clk);
            if (hasPc[r]) begin
                readReg(5'd0, v);
                checkPc(pcExp[r], v);
                checkWord("imAddr", pcExp[r], imAddr);
            end
            for (int i = 0; i < nChk[r]; i++) begin
                readReg(chkReg[r][i], v);
                checkWord($sformatf("r%0d", chkReg[r][i]), chkVal[r][i], v);
            end
            if (hasWr[r]) begin
                waitWrite(20);
                checkWrite(expWrAddr[r], expWrData[r], wrAddr, wrData);
                checkWord("dmWe strobe count", 32'd1, 32'(wrCount));
            end
        end
        // loop still counting after the handler returned, two cycles a pass
        repeat (10) @(negedge clk);
        readReg(5'd9, v);
        checkWord("r9", 32'd18, v);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: mipsDecoder.sv
// MIPS instruction decoder
`timescale 1ns/1ps

module mipsDecoder (
    input  mipsPkg::opcodeT   opcode,
    input  mipsPkg::functT    funct,
    input  logic [4:0]        rs,
    output mipsPkg::ctrlWordT ctrl
);

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = mipsPkg::aluAdd;

        case (opcode)
            mipsPkg::opSpec: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::aluSubu;
                    mipsPkg::fnOr:   ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnSrl:  ctrl.aluOp = mipsPkg::aluSrl;
                    mipsPkg::fnSltu: ctrl.aluOp = mipsPkg::aluSltu;
                    mipsPkg::fnNop: begin
                        ctrl.regDst   = 1'b0;
                        ctrl.regWrite = 1'b0;
                        ctrl.riFound  = (rs != 5'd0); // real sll is not supported
                    end
                    default: begin
                        ctrl.regDst   = 1'b0;
                        ctrl.regWrite = 1'b0;
                        ctrl.riFound  = 1'b1;
                    end
                endcase
            end
            mipsPkg::opAddiu: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            mipsPkg::opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsPkg::aluLui;
            end
            mipsPkg::opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            mipsPkg::opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            mipsPkg::opBeq: begin
                ctrl.branch   = 1'b1;
                ctrl.condZero = 1'b1;
                ctrl.aluOp    = mipsPkg::aluSubu;
            end
            mipsPkg::opBne: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = mipsPkg::aluSubu;
            end
            mipsPkg::opCop0: begin
                if (rs == 5'd0) begin // mfc0
                    ctrl.cp0ToReg = 1'b1;
                    ctrl.regWrite = 1'b1;
                end else if (rs == 5'd4) begin // mtc0
                    ctrl.cp0Write = 1'b1;
                end else if (rs == 5'd16 && funct == mipsPkg::fnEret) begin
                    ctrl.eretReq = 1'b1;
                end else begin
                    ctrl.riFound = 1'b1;
                end
            end
            default: ctrl.riFound = 1'b1;
        endcase

        // a store never writes back, the top relies on it for the rt port
        assert (!(ctrl.memWrite && ctrl.regWrite));
    end

endmodule

// File: mipsPkg.sv
// MIPS core types
package mipsPkg;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        opSpec  = 6'b000000,
        opBeq   = 6'b000100,
        opBne   = 6'b000101,
        opAddiu = 6'b001001,
        opLui   = 6'b001111,
        opCop0  = 6'b010000,
        opLw    = 6'b100011,
        opSw    = 6'b101011
    } opcodeT;

    // funct field, instr[5:0]
    typedef enum logic [5:0] {
        fnNop  = 6'h00, // sll encoding, only as all-zero nop
        fnSrl  = 6'h02,
        fnEret = 6'h18, // only under cop0 with co bit set
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnOr   = 6'h25,
        fnSltu = 6'h2b
    } functT;

    typedef enum logic [2:0] {
        aluAdd  = 3'd0,
        aluOr   = 3'd1,
        aluLui  = 3'd2,
        aluSrl  = 3'd3,
        aluSltu = 3'd4,
        aluSubu = 3'd5
    } aluOpT;

    typedef enum logic [1:0] {
        pcFlow = 2'd0, // sequential or branch target
        pcExc  = 2'd1, // exception handler
        pcEret = 2'd2  // back to EPC
    } pcSelT;

    typedef struct packed {
        logic  regDst;   // rd instead of rt
        logic  regWrite;
        logic  aluSrc;   // immediate as srcB
        aluOpT aluOp;
        logic  memWrite;
        logic  memToReg;
        logic  branch;
        logic  condZero; // beq when set, bne when clear
        logic  cp0ToReg; // mfc0
        logic  cp0Write; // mtc0
        logic  eretReq;
        logic  riFound;  // reserved instruction
    } ctrlWordT;

    typedef struct packed {
        logic riFound;
        logic eretReq;
        logic cp0Write;
    } cp0ReqT;

endpackage

// File: mipsRegFile.sv
// MIPS general register file
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsRegFile (
    input  logic               clk,
    input  logic [4:0]         dbgAddr,
    input  logic [4:0]         rAddrA,
    input  logic [4:0]         rAddrB,
    input  logic [4:0]         wAddr,
    output logic [`DATA_W-1:0] dbgData,
    output logic [`DATA_W-1:0] rDataA,
    output logic [`DATA_W-1:0] rDataB,
    input  logic [`DATA_W-1:0] wData,
    input  logic               wEn
);

    logic [`DATA_W-1:0] regs [32];

    // $zero is hardwired
    assign dbgData = (dbgAddr == 5'd0) ? '0 : regs[dbgAddr];
    assign rDataA  = (rAddrA == 5'd0) ? '0 : regs[rAddrA];
    assign rDataB  = (rAddrB == 5'd0) ? '0 : regs[rAddrB];

    always_ff @(posedge clk) begin
        if (wEn && wAddr != 5'd0) begin
            regs[wAddr] <= wData;
        end
    end

endmodule

// File: mips_macros.svh
// MIPS core constants
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath
`define DATA_W 32

// program counter after reset
`define RESET_VEC 32'h0000_0000

// fixed exception entry
`define EXC_HANDLER 32'h0000_0040

// coprocessor 0 register numbers
`define CP0_COUNT   5'd9
`define CP0_COMPARE 5'd11
`define CP0_STATUS  5'd12
`define CP0_CAUSE   5'd13
`define CP0_EPC     5'd14

// Cause.ExcCode values
`define EXC_INT 5'd0
`define EXC_RI  5'd10

`endif

// File: run.sh
#!/bin/bash
# Build and run the MIPS CPU testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mipsCpuTb -f mipsCpu.f -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
